/* logic/membridge_pkg.sv */
/* shared widths, APB offsets and bus structs for the memory bridge
   system addresses are counted in 64-bit words, windows are 16-word aligned */
`default_nettype none

package membridge_pkg;

    localparam int ADDR64_BITS   = 29;   // word address, byte address >> 3
    localparam int BURST_WORDS   = 16;   // longest AXI burst
    localparam int BUF_WORDS     = 512;  // page buffer depth
    localparam int BUF_ADDR_BITS = 9;
    localparam int LEN_BITS      = 10;   // 0..512 words
    localparam int FIFO_DEPTH    = 4;    // burst and data FIFOs, power of two

    localparam logic [7:0] REG_CTRL    = 8'h00;  // bit0 enable, bit1 start, bit2 reset addr
    localparam logic [7:0] REG_STATUS  = 8'h04;  // bit0 busy, bit1 done, bit2 error
    localparam logic [7:0] REG_LO_ADDR = 8'h08;
    localparam logic [7:0] REG_SIZE    = 8'h0C;
    localparam logic [7:0] REG_START   = 8'h10;
    localparam logic [7:0] REG_LEN     = 8'h14;

    typedef logic [63:0]            word_t;
    typedef logic [ADDR64_BITS-1:0] addr64_t;
    typedef logic [3:0]             burst_len_t;  // beats - 1

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        addr64_t             lo_addr;     // window base
        addr64_t             size;        // window size
        addr64_t             start_off;   // offset inside window
        logic [LEN_BITS-1:0] len;         // words to copy
        logic                reset_addr;  // restart from start_off
    } xfer_cfg_t;

    typedef struct packed {
        logic [31:0] awaddr;  // byte address
        burst_len_t  awlen;
    } axi_aw_t;

    typedef struct packed {
        word_t wdata;
        logic  wlast;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] bresp;
    } axi_b_t;

endpackage

`default_nettype wire

/* logic/page_buffer.sv */
/* 512 x 64 buffer, one write and one registered read port
   reading and writing the same word in one cycle returns the old word */
`timescale 1ns/100ps
`default_nettype none

module page_buffer import membridge_pkg::*; (
    input  logic                     hclk,
    input  logic                     we_i,
    input  logic [BUF_ADDR_BITS-1:0] waddr_i,
    input  word_t                    wdata_i,
    input  logic                     rd_en_i,
    input  logic [BUF_ADDR_BITS-1:0] raddr_i,
    output word_t                    rdata_o
);

    word_t mem [BUF_WORDS];

    always_ff @(posedge hclk) begin
        if (we_i)    mem[waddr_i] <= wdata_i;
        if (rd_en_i) rdata_o <= mem[raddr_i];  // one cycle latency
    end

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
/* first-word-fall-through FIFO, DEPTH must be a power of two
   data_o is valid whenever empty_o is low */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     hclk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);

    payload_t                 mem [DEPTH];
    logic [$clog2(DEPTH):0]   wr_ptr;  // extra msb tells full from empty
    logic [$clog2(DEPTH):0]   rd_ptr;
    logic [$clog2(DEPTH):0]   count;

    assign count   = wr_ptr - rd_ptr;
    assign full_o  = count == ($clog2(DEPTH) + 1)'(DEPTH);
    assign empty_o = count == '0;
    assign data_o  = mem[rd_ptr[$clog2(DEPTH)-1:0]];  // head shows through

    always_ff @(posedge hclk) begin
        if (push_i) mem[wr_ptr[$clog2(DEPTH)-1:0]] <= data_i;
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge hclk) disable iff (rst) push_i |-> !full_o)
        else $error("push into full FIFO");
    a_no_underflow: assert property (@(posedge hclk) disable iff (rst) pop_i |-> !empty_o)
        else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* logic/bridge_regs.sv */
/* zero-wait APB register file; writes land at the end of the access cycle
   start is dropped while busy or when enable is not set in the same write */
`timescale 1ns/100ps
`default_nettype none

module bridge_regs import membridge_pkg::*; (
    input  logic      hclk,
    input  logic      rst,
    input  apb_req_t  apb_i,
    output apb_rsp_t  apb_o,
    input  logic      xfer_end_i,
    input  logic      resp_err_i,
    output xfer_cfg_t cfg_o,
    output logic      start_o,
    output logic      enable_o
);

    logic                wr;         // access phase write
    logic                start_req;  // accepted start
    logic                enable_q;
    logic                reset_addr_q;
    logic                busy_q;
    logic                done_q;
    logic                err_q;
    addr64_t             lo_addr_q;
    addr64_t             size_q;
    addr64_t             start_off_q;
    logic [LEN_BITS-1:0] len_q;
    logic [31:0]         rdata;

    assign wr        = apb_i.psel && apb_i.penable && apb_i.pwrite;
    assign start_req = wr && (apb_i.paddr == REG_CTRL) && !busy_q
                       && apb_i.pwdata[0] && apb_i.pwdata[1];  // enable and start together

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            enable_q     <= 1'b0;
            reset_addr_q <= 1'b0;
            lo_addr_q    <= '0;
            size_q       <= '0;
            start_off_q  <= '0;
            len_q        <= '0;
        end else if (wr) begin
            case (apb_i.paddr)
                REG_CTRL: begin
                    enable_q     <= apb_i.pwdata[0];
                    reset_addr_q <= apb_i.pwdata[2];
                end
                REG_LO_ADDR: begin
                    lo_addr_q   <= {apb_i.pwdata[ADDR64_BITS-1:4], 4'h0};  // 16-word aligned
                    start_off_q <= '0;                                   // new window, offset 0
                end
                REG_SIZE:  size_q      <= {apb_i.pwdata[ADDR64_BITS-1:4], 4'h0};
                REG_START: start_off_q <= {apb_i.pwdata[ADDR64_BITS-1:4], 4'h0};
                REG_LEN:   len_q       <= apb_i.pwdata[LEN_BITS-1:0];  // any length
                default: ;
            endcase
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            start_o <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            start_o <= start_req;  // one cycle after the write
            if (start_req)       busy_q <= 1'b1;
            else if (xfer_end_i) busy_q <= 1'b0;
            if (start_req || !enable_q) done_q <= 1'b0;  // disable or restart clears done
            else if (xfer_end_i)        done_q <= 1'b1;
            if (start_req)       err_q <= 1'b0;
            else if (resp_err_i) err_q <= 1'b1;  // sticky until next start
        end
    end

    always_comb begin
        rdata = '0;
        case (apb_i.paddr)
            REG_CTRL:    rdata = {29'h0, reset_addr_q, 1'b0, enable_q};  // start reads 0
            REG_STATUS:  rdata = {29'h0, err_q, done_q, busy_q};
            REG_LO_ADDR: rdata = 32'(lo_addr_q);
            REG_SIZE:    rdata = 32'(size_q);
            REG_START:   rdata = 32'(start_off_q);
            REG_LEN:     rdata = 32'(len_q);
            default: ;
        endcase
    end

    assign apb_o    = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
    assign enable_o = enable_q;
    assign cfg_o    = '{lo_addr: lo_addr_q, size: size_q, start_off: start_off_q,
                        len: len_q, reset_addr: reset_addr_q};

endmodule

`default_nettype wire

/* logic/burst_issuer.sv */
/* issues INCR bursts of up to 16 words into a circular window
   a partial last burst leaves the next transfer off the 16-word grid */
`timescale 1ns/100ps
`default_nettype none

module burst_issuer import membridge_pkg::*; (
    input  logic       hclk,
    input  logic       rst,
    input  xfer_cfg_t  cfg_i,
    input  logic       start_i,
    input  logic       enable_i,
    output axi_aw_t    aw_o,
    output logic       awvalid_o,
    input  logic       awready_i,
    input  logic       bvalid_i,
    input  axi_b_t     b_i,
    output burst_len_t blen_o,
    output logic       blen_push_o,
    input  logic       blen_full_i,
    output logic       xfer_end_o,
    output logic       resp_err_o
);

    addr64_t             rel_addr;    // offset from window base
    logic [LEN_BITS-1:0] left;        // words not yet issued
    logic [5:0]          pending;     // bursts awaiting B, at most 32
    logic                active;
    logic                aw_hs;
    logic                last_burst;  // fewer than 16 words remain
    logic                last_slot;   // top 16 words of window
    axi_aw_t             aw_q;
    logic                awvalid_q;

    assign aw_hs      = awvalid_q && awready_i;
    assign last_burst = left < LEN_BITS'(BURST_WORDS);
    assign last_slot  = rel_addr[ADDR64_BITS-1:4] == (cfg_i.size[ADDR64_BITS-1:4] - 1'b1);

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            rel_addr  <= '0;
            left      <= '0;
            active    <= 1'b0;
            awvalid_q <= 1'b0;
        end else begin
            if (start_i) begin
                active <= 1'b1;
                left   <= cfg_i.len;
                if (cfg_i.reset_addr) rel_addr <= cfg_i.start_off;  // else continue
            end else if (aw_hs) begin
                awvalid_q <= 1'b0;
                left      <= last_burst ? '0 : left - LEN_BITS'(BURST_WORDS);
                if (last_burst)     rel_addr <= rel_addr + ADDR64_BITS'(left[3:0]);
                else if (last_slot) rel_addr <= '0;  // wrap to window base
                else                rel_addr <= rel_addr + ADDR64_BITS'(BURST_WORDS);
            end else if (!awvalid_q && active && enable_i && (left != '0) && !blen_full_i) begin
                awvalid_q <= 1'b1;  // aw_q loads on this same edge
            end
            if (xfer_end_o) active <= 1'b0;
        end
    end

    // sum is registered while idle, so it is stable once valid rises
    always_ff @(posedge hclk) begin
        if (!awvalid_q) begin
            aw_q.awaddr <= {cfg_i.lo_addr + rel_addr, 3'b000};
            aw_q.awlen  <= last_burst ? burst_len_t'(left[3:0] - 1'b1)
                                      : burst_len_t'(BURST_WORDS - 1);
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            case ({aw_hs, bvalid_i})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    assign xfer_end_o  = active && (left == '0) && !awvalid_q && (pending == '0);
    assign resp_err_o  = bvalid_i && (b_i.bresp != 2'b00);  // SLVERR or DECERR
    assign aw_o        = aw_q;
    assign awvalid_o   = awvalid_q;
    assign blen_o      = aw_q.awlen;
    assign blen_push_o = aw_hs;  // W side learns the length at handshake

    a_b_expected: assert property (@(posedge hclk) disable iff (rst)
        bvalid_i |-> pending != '0)
        else $error("B response with no burst outstanding");

endmodule

`default_nettype wire

/* logic/wdata_stream.sv */
/* reads only words that belong to the burst at the head of the length FIFO
   so nothing is left in the data FIFO once a transfer ends */
`timescale 1ns/100ps
`default_nettype none

module wdata_stream import membridge_pkg::*; (
    input  logic                     hclk,
    input  logic                     rst,
    input  logic                     start_i,
    input  burst_len_t               blen_i,
    input  logic                     blen_empty_i,
    output logic                     blen_pop_o,
    output logic                     rd_en_o,
    output logic [BUF_ADDR_BITS-1:0] rd_addr_o,
    input  word_t                    rd_data_i,
    output axi_w_t                   w_o,
    output logic                     wvalid_o,
    input  logic                     wready_i
);

    logic [BUF_ADDR_BITS-1:0] idx;       // next buffer word
    logic [4:0]               rd_cnt;    // reads issued for head burst
    burst_len_t               beat_cnt;  // beats sent in head burst
    logic [2:0]               credit;    // words queued plus read in flight
    logic                     rd_pend;   // buffer data arrives next cycle
    logic                     beat;
    logic                     d_empty;
    word_t                    d_out;

    assign rd_en_o    = !blen_empty_i && (rd_cnt <= {1'b0, blen_i})
                        && (credit < 3'(FIFO_DEPTH));
    assign rd_addr_o  = idx;
    assign wvalid_o   = !d_empty;
    assign beat       = wvalid_o && wready_i;
    assign w_o        = '{wdata: d_out, wlast: (beat_cnt == blen_i)};
    assign blen_pop_o = beat && w_o.wlast;  // burst retired on its last beat

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            idx      <= '0;
            rd_cnt   <= '0;
            beat_cnt <= '0;
            credit   <= '0;
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= rd_en_o;
            credit  <= credit + 3'(rd_en_o) - 3'(beat);
            if (start_i)      idx <= '0;  // copy always begins at word 0
            else if (rd_en_o) idx <= idx + 1'b1;
            if (start_i || blen_pop_o) rd_cnt <= '0;
            else if (rd_en_o)          rd_cnt <= rd_cnt + 1'b1;
            if (start_i || blen_pop_o) beat_cnt <= '0;
            else if (beat)             beat_cnt <= beat_cnt + 1'b1;
        end
    end

    sync_fifo #(
        .payload_t (word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_data_fifo (
        .hclk    (hclk),
        .rst     (rst),
        .push_i  (rd_pend),
        .data_i  (rd_data_i),
        .full_o  (),           // credit keeps it from filling
        .pop_i   (beat),
        .data_o  (d_out),
        .empty_o (d_empty)
    );

endmodule

`default_nettype wire

/* logic/membridge_top.sv */
/* page buffer to AXI write bridge; slave must accept 64-bit INCR bursts, full strobes, ID 0
   load the buffer only while STATUS busy is clear */
`timescale 1ns/100ps
`default_nettype none

module membridge_top import membridge_pkg::*; (
    input  logic                     hclk,
    input  logic                     rst,
    input  apb_req_t                 apb_i,
    output apb_rsp_t                 apb_o,
    input  logic                     buf_we_i,
    input  logic [BUF_ADDR_BITS-1:0] buf_waddr_i,
    input  word_t                    buf_wdata_i,
    output axi_aw_t                  aw_o,
    output logic                     awvalid_o,
    input  logic                     awready_i,
    output axi_w_t                   w_o,
    output logic                     wvalid_o,
    input  logic                     wready_i,
    input  axi_b_t                   b_i,
    input  logic                     bvalid_i,
    output logic                     bready_o
);

    xfer_cfg_t                cfg;
    logic                     start_pulse;
    logic                     enable;
    logic                     xfer_end;
    logic                     resp_err;
    burst_len_t               blen_in;   // issuer side
    burst_len_t               blen_out;  // W side head
    logic                     blen_push;
    logic                     blen_pop;
    logic                     blen_full;
    logic                     blen_empty;
    logic                     rd_en;
    logic [BUF_ADDR_BITS-1:0] rd_addr;
    word_t                    rd_data;

    assign bready_o = 1'b1;  // responses always taken

    bridge_regs u_regs (
        .hclk(hclk), .rst(rst), .apb_i(apb_i), .apb_o(apb_o),
        .xfer_end_i(xfer_end), .resp_err_i(resp_err),
        .cfg_o(cfg), .start_o(start_pulse), .enable_o(enable)
    );

    burst_issuer u_issuer (
        .hclk(hclk), .rst(rst), .cfg_i(cfg), .start_i(start_pulse), .enable_i(enable),
        .aw_o(aw_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
        .bvalid_i(bvalid_i), .b_i(b_i),
        .blen_o(blen_in), .blen_push_o(blen_push), .blen_full_i(blen_full),
        .xfer_end_o(xfer_end), .resp_err_o(resp_err)
    );

    sync_fifo #(.payload_t(burst_len_t), .DEPTH(FIFO_DEPTH)) u_blen_fifo (
        .hclk(hclk), .rst(rst), .push_i(blen_push), .data_i(blen_in), .full_o(blen_full),
        .pop_i(blen_pop), .data_o(blen_out), .empty_o(blen_empty)
    );

    wdata_stream u_wdata (
        .hclk(hclk), .rst(rst), .start_i(start_pulse),
        .blen_i(blen_out), .blen_empty_i(blen_empty), .blen_pop_o(blen_pop),
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .w_o(w_o), .wvalid_o(wvalid_o), .wready_i(wready_i)
    );

    page_buffer u_buf (
        .hclk(hclk), .we_i(buf_we_i), .waddr_i(buf_waddr_i), .wdata_i(buf_wdata_i),
        .rd_en_i(rd_en), .raddr_i(rd_addr), .rdata_o(rd_data)
    );

endmodule

`default_nettype wire

/* test/tb_axi_mem.sv */
/* AXI write slave model, one B per burst after its last W beat, bready assumed high
   all outputs change on the falling edge, accepted AW and W beats are logged in order */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem import membridge_pkg::*; #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic    hclk,
    input  logic    rst,
    input  logic    stall_i,  // random ready drops
    input  logic    err_i,    // answer with SLVERR
    input  axi_aw_t aw_i,
    input  logic    awvalid_i,
    output logic    awready_o,
    input  axi_w_t  w_i,
    input  logic    wvalid_i,
    output logic    wready_o,
    output axi_b_t  b_o,
    output logic    bvalid_o,
    input  logic    bready_i
);

    axi_aw_t aw_log [64];
    axi_w_t  w_log [1024];
    int      aw_count;
    int      w_count;
    int      owed;      // bursts still waiting for B
    logic    hold_err;  // AW changed while waiting
    logic    aw_wait;
    logic    aw_rdy;
    logic    w_rdy;
    axi_aw_t aw_prev;
    integer  seed;

    // ready chosen here holds until the next falling edge, so the handshake is known now
    always @(negedge hclk or posedge rst) begin
        if (rst) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            b_o       <= '0;
            aw_count  = 0;
            w_count   = 0;
            owed      = 0;
            hold_err  = 1'b0;
            aw_wait   = 1'b0;
            seed      = SEED;
        end else begin
            if (aw_wait && (!awvalid_i || aw_i != aw_prev)) hold_err = 1'b1;
            if (!bvalid_o || bready_i) begin
                bvalid_o  <= owed > 0;
                b_o.bresp <= err_i ? 2'b10 : 2'b00;  // SLVERR when asked
                if (owed > 0) owed--;
            end
            aw_rdy = !stall_i || (($random(seed) & 3) != 0);  // about one stall in four
            w_rdy  = !stall_i || (($random(seed) & 3) != 0);
            awready_o <= aw_rdy;
            wready_o  <= w_rdy;
            aw_wait = awvalid_i && !aw_rdy;
            aw_prev = aw_i;
            if (awvalid_i && aw_rdy) begin
                aw_log[aw_count] = aw_i;
                aw_count++;
            end
            if (wvalid_i && w_rdy) begin
                w_log[w_count] = w_i;
                w_count++;
                if (w_i.wlast) owed++;  // B goes out from the next falling edge on
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_membridge.sv */
/* directed tests of the memory bridge against a window address model
   stops at the first mismatch, a watchdog bounds the whole run */
`timescale 1ns/100ps
`default_nettype none

module tb_membridge import membridge_pkg::*; ();

    localparam int          CLK_PERIOD = 8;
    localparam logic [31:0] SEED_INIT  = 32'hd4c6_e937;
    localparam int          WDOG_MULT  = 200;  // cycles allowed per word
    localparam int          LEN_SHORT  = 5;
    localparam int          LEN_WRAP   = 40;
    localparam int          LEN_STALL  = 45;
    localparam int          LEN_CONT   = 3;
    localparam int          LEN_ERR    = 5;
    localparam int          TOTAL_WORDS = LEN_SHORT + LEN_WRAP + LEN_STALL + LEN_CONT + LEN_ERR;

    logic                     hclk;
    logic                     rst;
    apb_req_t                 apb_req;
    apb_rsp_t                 apb_rsp;
    logic                     buf_we;
    logic [BUF_ADDR_BITS-1:0] buf_waddr;
    word_t                    buf_wdata;
    axi_aw_t                  aw;
    logic                     awvalid;
    logic                     awready;
    axi_w_t                   w;
    logic                     wvalid;
    logic                     wready;
    axi_b_t                   b;
    logic                     bvalid;
    logic                     bready;
    logic                     stall_en;
    logic                     err_en;
    integer                   seed;
    word_t                    ref_buf [BUF_WORDS];  // what the buffer should hold
    addr64_t                  rel_model;            // expected offset in window
    int                       aw_base;              // log entries already checked
    int                       w_base;

    membridge_top dut (
        .hclk(hclk), .rst(rst), .apb_i(apb_req), .apb_o(apb_rsp),
        .buf_we_i(buf_we), .buf_waddr_i(buf_waddr), .buf_wdata_i(buf_wdata),
        .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
        .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
        .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
    );

    tb_axi_mem #(.SEED(SEED_INIT)) mem (
        .hclk(hclk), .rst(rst), .stall_i(stall_en), .err_i(err_en),
        .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
        .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
        .b_o(b), .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    initial begin
        #(TOTAL_WORDS * WDOG_MULT * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_aw(input axi_aw_t got, input axi_aw_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s got addr %h len %0d expected addr %h len %0d",
                               $time, what, got.awaddr, got.awlen, exp.awaddr, exp.awlen));
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge hclk);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
        @(negedge hclk);
        apb_req.penable = 1'b1;  // write lands on the next rising edge
        @(negedge hclk);
        check_reg({30'h0, apb_rsp.pready, apb_rsp.pslverr}, 32'h2, "APB write pready, pslverr");
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge hclk);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: 32'h0};
        @(negedge hclk);
        apb_req.penable = 1'b1;
        @(negedge hclk);
        check_reg({30'h0, apb_rsp.pready, apb_rsp.pslverr}, 32'h2, "APB read pready, pslverr");
        data    = apb_rsp.prdata;  // zero-wait, stable here
        apb_req = '0;
    endtask

    task automatic load_buffer();
        for (int i = 0; i < BUF_WORDS; i++) begin
            @(negedge hclk);
            ref_buf[i] = {$random(seed), $random(seed)};
            buf_we     = 1'b1;
            buf_waddr  = BUF_ADDR_BITS'(i);
            buf_wdata  = ref_buf[i];
        end
        @(negedge hclk);
        buf_we = 1'b0;
    endtask

    task automatic configure(input logic [31:0] lo, input logic [31:0] size,
                             input logic [31:0] start, input logic [31:0] len);
        apb_write(REG_LO_ADDR, lo);  // clears START, so it goes first
        apb_write(REG_SIZE, size);
        apb_write(REG_START, start);
        apb_write(REG_LEN, len);
    endtask

    task automatic wait_done(output logic [31:0] status);
        do begin
            apb_read(REG_STATUS, status);
        end while (!status[1]);
    endtask

    task automatic run_transfer(input logic [31:0] ctrl, input logic [31:0] exp_status);
        logic [31:0] status;
        apb_write(REG_CTRL, ctrl);
        apb_read(REG_STATUS, status);
        check_reg(status & 32'h1, 32'h1, "busy after start");
        wait_done(status);
        check_reg(status, exp_status, "status at end of transfer");
    endtask

    // bursts of 16 or the remainder, full bursts wrap at the top slot of the window
    task automatic verify_transfer(input addr64_t lo, input addr64_t size, input int len);
        int      left;
        int      n;
        axi_aw_t exp_aw;
        left = len;
        check_reg(32'(mem.aw_count), 32'(aw_base + (len + BURST_WORDS - 1) / BURST_WORDS),
                  "AW count");
        check_reg(32'(mem.w_count), 32'(w_base + len), "W beat count");
        while (left > 0) begin
            n = (left >= BURST_WORDS) ? BURST_WORDS : left;
            exp_aw.awaddr = {lo + rel_model, 3'b000};
            exp_aw.awlen  = burst_len_t'(n - 1);
            check_aw(mem.aw_log[aw_base], exp_aw, "burst address and length");
            aw_base++;
            for (int k = 0; k < n; k++) begin
                check_word(mem.w_log[w_base].wdata, ref_buf[len - left + k], "beat data");
                check_reg(32'(mem.w_log[w_base].wlast), 32'(k == n - 1), "wlast");
                w_base++;
            end
            if (n < BURST_WORDS) rel_model = rel_model + ADDR64_BITS'(n);
            else if (rel_model + ADDR64_BITS'(BURST_WORDS) >= size) rel_model = '0;
            else rel_model = rel_model + ADDR64_BITS'(BURST_WORDS);
            left -= n;
        end
    endtask

    task automatic test_regs();
        logic [31:0] data;
        apb_write(REG_LO_ADDR, 32'h0000_1237);
        apb_write(REG_SIZE, 32'h0000_0045);
        apb_write(REG_START, 32'h0000_002b);
        apb_write(REG_LEN, 32'h0000_01ff);
        apb_read(REG_LO_ADDR, data);
        check_reg(data, 32'h0000_1230, "LO_ADDR readback");
        apb_read(REG_SIZE, data);
        check_reg(data, 32'h0000_0040, "SIZE readback");
        apb_read(REG_START, data);
        check_reg(data, 32'h0000_0020, "START readback");
        apb_read(REG_LEN, data);
        check_reg(data, 32'h0000_01ff, "LEN readback");
        apb_write(REG_LO_ADDR, 32'h0000_0100);
        apb_read(REG_START, data);
        check_reg(data, 32'h0, "START after LO_ADDR write");
    endtask

    task automatic test_short();
        configure(32'h200, 32'h40, 32'h0, LEN_SHORT);
        rel_model = '0;
        run_transfer(32'h7, 32'h2);  // enable, start, reset address
        verify_transfer(29'h200, 29'h40, LEN_SHORT);
    endtask

    task automatic test_wrap();
        configure(32'h400, 32'd32, 32'd16, LEN_WRAP);
        rel_model = 29'd16;
        run_transfer(32'h7, 32'h2);
        verify_transfer(29'h400, 29'd32, LEN_WRAP);  // 16, 0, 16
    endtask

    task automatic test_backpressure();
        load_buffer();
        stall_en <= 1'b1;
        configure(32'h800, 32'd64, 32'd32, LEN_STALL);
        rel_model = 29'd32;
        run_transfer(32'h7, 32'h2);
        verify_transfer(29'h800, 29'd64, LEN_STALL);
        if (mem.hold_err) stop_run("awvalid or its address changed before awready");
        stall_en <= 1'b0;
    endtask

    task automatic test_continue_err();
        logic [31:0] data;
        apb_write(REG_LEN, LEN_CONT);
        run_transfer(32'h3, 32'h2);  // no reset address, carry on
        verify_transfer(29'h800, 29'd64, LEN_CONT);
        apb_write(REG_LEN, LEN_ERR);
        err_en <= 1'b1;
        run_transfer(32'h3, 32'h6);  // done and error
        verify_transfer(29'h800, 29'd64, LEN_ERR);
        err_en <= 1'b0;
        apb_write(REG_CTRL, 32'h0);
        apb_read(REG_STATUS, data);
        check_reg(data & 32'h3, 32'h0, "done cleared by disable");
    endtask

    initial begin
        seed      = SEED_INIT;
        rst       = 1'b1;
        apb_req   = '0;
        buf_we    = 1'b0;
        buf_waddr = '0;
        buf_wdata = '0;
        stall_en  = 1'b0;
        err_en    = 1'b0;
        aw_base   = 0;
        w_base    = 0;
        rel_model = '0;
        repeat (5) @(posedge hclk);
        @(negedge hclk);
        rst = 1'b0;
        test_regs();
        load_buffer();
        test_short();
        test_wrap();
        test_backpressure();
        test_continue_err();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/membridge_pkg.sv
logic/page_buffer.sv
logic/sync_fifo.sv
logic/bridge_regs.sv
logic/burst_issuer.sv
logic/wdata_stream.sv
logic/membridge_top.sv
test/tb_axi_mem.sv
test/tb_membridge.sv

/* Makefile */
# Verilator build and run of the memory bridge testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_membridge
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
